// File: cache_consts.svh
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// geometry
`define CACHE_SETS      256
`define INDEX_W         8
`define TAG_W           20
`define OFFSET_W        4
`define BANKS           4
`define WORD_W          32
`define LINE_W          128

// memory request type codes for both read and write channels
`define RD_TYPE_WORD    3'b010
`define RD_TYPE_LINE    3'b100

// victim selection
`define LFSR_SEED       8'd1

`endif

// File: cache_pkg.sv
`include "cache_consts.svh"

package cache_pkg;

    typedef logic [`WORD_W-1:0] word_t;
    typedef word_t [`BANKS-1:0] line_t;     // bank 0 in the low word

    typedef struct packed {
        logic                   op;         // 1 = store
        logic [`INDEX_W-1:0]    index;
        logic [`TAG_W-1:0]      tag;
        logic [`OFFSET_W-1:0]   offset;
        logic [3:0]             wstrb;
        word_t                  wdata;
        logic                   cached;
    } cpu_req_t;

    typedef struct packed {
        logic [`TAG_W-1:0]  tag;
        logic               valid;
        logic               dirty;
    } meta_t;

    typedef struct packed {
        logic [2:0]     rtype;
        logic [31:0]    addr;
    } mem_rd_req_t;

    typedef struct packed {
        logic [2:0]     wtype;
        logic [31:0]    addr;
        logic [3:0]     wstrb;
        line_t          data;
    } mem_wr_req_t;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_miss,
        st_replace,
        st_refill
    } main_state_t;

    // byte-strobed store on top of an existing word
    function automatic word_t merge_word(logic [3:0] wstrb, word_t wdata, word_t old);
        word_t res;
        for (int i = 0; i < 4; i++) begin
            res[8*i +: 8] = wstrb[i] ? wdata[8*i +: 8] : old[8*i +: 8];
        end
        return res;
    endfunction

endpackage

// File: sync_ram.sv
`include "cache_consts.svh"

module sync_ram #(
    parameter type entry_t        = logic [`WORD_W-1:0],
    parameter bit  CLEAR_ON_RESET = 1'b0
) (
    input  logic                clk,
    input  logic                resetn,
    input  logic                en,
    input  logic                we,
    input  logic [`INDEX_W-1:0] addr,
    input  entry_t              wdata,
    output entry_t              rdata
);

    entry_t mem [`CACHE_SETS];

    // read returns the old entry when writing the same address
    always_ff @(posedge clk) begin
        if (!resetn) begin
            if (CLEAR_ON_RESET) begin
                for (int i = 0; i < `CACHE_SETS; i++) begin
                    mem[i] <= '0;
                end
            end
        end else if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end
            rdata <= mem[addr];
        end
    end

endmodule

// File: cache_way.sv
`include "cache_consts.svh"

module cache_way import cache_pkg::*; (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic [`INDEX_W-1:0]     index,
    input  logic [`TAG_W-1:0]       req_tag,
    input  logic                    meta_we,
    input  meta_t                   meta_wdata,
    input  logic [`BANKS-1:0]       bank_we,
    input  word_t [`BANKS-1:0]      bank_wdata,
    output meta_t                   meta,
    output logic                    hit,
    output word_t [`BANKS-1:0]      bank_data
);

    logic [`TAG_W-1:0] tag_q;

    // tag follows the RAM address by one cycle to line up with meta
    always_ff @(posedge clk) begin
        tag_q <= req_tag;
    end

    sync_ram #(
        .entry_t        (meta_t),
        .CLEAR_ON_RESET (1'b1)
    ) meta_ram (
        .clk    (clk),
        .resetn (resetn),
        .en     (1'b1),
        .we     (meta_we),
        .addr   (index),
        .wdata  (meta_wdata),
        .rdata  (meta)
    );

    for (genvar b = 0; b < `BANKS; b++) begin : g_bank
        sync_ram #(
            .entry_t        (word_t),
            .CLEAR_ON_RESET (1'b0)
        ) bank_ram (
            .clk    (clk),
            .resetn (resetn),
            .en     (1'b1),
            .we     (bank_we[b]),
            .addr   (index),
            .wdata  (bank_wdata[b]),
            .rdata  (bank_data[b])
        );
    end

    assign hit = meta.valid && meta.tag == tag_q;   // cached check is in the controller

endmodule

// File: store_buffer.sv
`include "cache_consts.svh"

module store_buffer import cache_pkg::*; (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    load,
    input  cpu_req_t                req,
    input  logic                    hit_way,
    input  word_t                   hit_word,
    input  logic [`INDEX_W-1:0]     new_index,
    input  logic [1:0]              new_bank,
    input  logic                    new_is_read,
    output logic                    busy,
    output logic                    wr_way,
    output logic [`INDEX_W-1:0]     wr_index,
    output logic [1:0]              wr_bank,
    output word_t                   wr_word,
    output logic                    conflict
);

    cpu_req_t req_d;    // request seen last cycle = the one now in lookup
    logic     same_word;
    logic     read_blocked;

    always_ff @(posedge clk) begin
        req_d <= req;
        if (load) begin
            wr_way   <= hit_way;
            wr_index <= req_d.index;
            wr_bank  <= req_d.offset[3:2];
            wr_word  <= merge_word(req_d.wstrb, req_d.wdata, hit_word);
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy <= 1'b0;
        end else begin
            busy <= load;
        end
    end

    // store still in lookup and ram not yet written
    assign same_word = load && new_index == req_d.index && new_bank == req_d.offset[3:2];

    // while writing, the written way sits at wr_index
    assign read_blocked = same_word || busy && (new_index != wr_index || new_bank == wr_bank);

    // a new store would merge into a stale word, so stores wait for the buffer
    assign conflict = new_is_read ? read_blocked : (load || busy);

endmodule

// File: cache_ctrl.sv
`include "cache_consts.svh"

module cache_ctrl import cache_pkg::*; (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        valid,
    input  cpu_req_t                    req,
    output logic                        addr_ok,
    output logic                        data_ok,
    output word_t                       rdata,
    input  logic [1:0]                  way_hit,
    input  meta_t [1:0]                 way_meta,
    input  line_t [1:0]                 way_data,
    output logic [`INDEX_W-1:0]         way_index,
    output logic [1:0]                  meta_we,
    output meta_t                       meta_wdata,
    output logic [1:0][`BANKS-1:0]      refill_we,
    output word_t                       refill_word,
    output logic                        sb_load,
    input  logic                        sb_conflict,
    output logic                        rd_req,
    output mem_rd_req_t                 rd_info,
    input  logic                        rd_rdy,
    input  logic                        ret_valid,
    input  logic                        ret_last,
    input  word_t                       ret_data,
    output logic                        wr_req,
    output mem_wr_req_t                 wr_info,
    input  logic                        wr_rdy,
    input  logic                        wr_bvalid
);

    main_state_t    state;
    main_state_t    state_next;
    cpu_req_t       req_q;
    logic [1:0]     bank;
    logic           cache_hit;
    logic           uc_store;
    logic           uc_wr_pending;
    logic           replace_first;
    logic [1:0]     refill_cnt;
    logic           refill_beat;
    logic           refill_done;
    logic [7:0]     lfsr;
    logic           victim;
    meta_t          victim_meta;
    meta_t          dirty_meta_q;
    logic [1:0]     dirty_we_q;

    assign bank        = req_q.offset[3:2];
    assign cache_hit   = |way_hit && req_q.cached;
    assign uc_store    = !req_q.cached && req_q.op;
    assign refill_beat = state == st_refill && ret_valid;
    assign refill_done = refill_beat && ret_last;
    assign victim      = lfsr[0];
    assign victim_meta = way_meta[victim];

    assign addr_ok = (state == st_idle || state == st_lookup && cache_hit)
                     && !sb_conflict && !uc_wr_pending;

    // stores complete in lookup, loads on a hit or on their refill beat
    assign data_ok = state == st_lookup && (cache_hit || req_q.op)
                     || refill_beat && !req_q.op && (!req_q.cached || refill_cnt == bank);

    assign rdata     = state == st_lookup ? way_data[way_hit[1]][bank] : ret_data;
    assign sb_load   = state == st_lookup && cache_hit && req_q.op;
    assign way_index = addr_ok ? req.index : req_q.index;   // miss path rereads its own set

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (valid && addr_ok) begin
                    state_next = st_lookup;
                end
            end
            st_lookup: begin
                if (!cache_hit) begin
                    state_next = st_miss;
                end else if (!(valid && addr_ok)) begin
                    state_next = st_idle;
                end
            end
            st_miss: begin
                if (wr_rdy) begin
                    state_next = st_replace;
                end
            end
            st_replace: begin
                if (uc_store) begin
                    state_next = st_idle;       // nothing to read back
                end else if (rd_rdy) begin
                    state_next = st_refill;
                end
            end
            st_refill: begin
                if (refill_done) begin
                    state_next = st_idle;
                end
            end
            default: state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state         <= st_idle;
            replace_first <= 1'b0;
            uc_wr_pending <= 1'b0;
            refill_cnt    <= 2'd0;
            lfsr          <= `LFSR_SEED;
            dirty_we_q    <= 2'b00;
        end else begin
            state         <= state_next;
            replace_first <= state == st_miss && wr_rdy;
            if (wr_req && !req_q.cached) begin
                uc_wr_pending <= 1'b1;
            end else if (wr_bvalid) begin
                uc_wr_pending <= 1'b0;
            end
            if (refill_done) begin
                refill_cnt <= 2'd0;
            end else if (refill_beat) begin
                refill_cnt <= refill_cnt + 2'd1;
            end
            if (refill_done && req_q.cached) begin
                lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
            end
            dirty_we_q <= sb_load ? way_hit : 2'b00;    // lands with the store buffer write
        end
    end

    always_ff @(posedge clk) begin
        if (valid && addr_ok) begin
            req_q <= req;
        end
        if (sb_load) begin
            dirty_meta_q <= '{tag: req_q.tag, valid: 1'b1, dirty: 1'b1};
        end
    end

    always_comb begin
        meta_we    = dirty_we_q;
        meta_wdata = dirty_meta_q;
        if (refill_done && req_q.cached) begin
            meta_we[victim] = 1'b1;
            meta_wdata      = '{tag: req_q.tag, valid: 1'b1, dirty: req_q.op};
        end
    end

    always_comb begin
        refill_we = '0;
        if (refill_beat && req_q.cached) begin
            refill_we[victim][refill_cnt] = 1'b1;
        end
    end

    // write-allocate merges the pending store into its returned word
    assign refill_word = req_q.op && refill_cnt == bank
                         ? merge_word(req_q.wstrb, req_q.wdata, ret_data) : ret_data;

    assign rd_req        = state == st_replace && (req_q.cached || !req_q.op);
    assign rd_info.rtype = req_q.cached ? `RD_TYPE_LINE : `RD_TYPE_WORD;
    assign rd_info.addr  = {req_q.tag, req_q.index,
                            req_q.cached ? {`OFFSET_W{1'b0}} : req_q.offset};

    // one pulse for a victim write-back or uncached store
    assign wr_req = replace_first
                    && (req_q.cached ? victim_meta.valid && victim_meta.dirty : req_q.op);

    assign wr_info.wtype = req_q.cached ? `RD_TYPE_LINE : `RD_TYPE_WORD;
    assign wr_info.addr  = req_q.cached ? {victim_meta.tag, req_q.index, {`OFFSET_W{1'b0}}}
                                        : {req_q.tag, req_q.index, req_q.offset};
    assign wr_info.wstrb = req_q.cached ? 4'b1111 : req_q.wstrb;
    assign wr_info.data  = req_q.cached ? way_data[victim] : {`BANKS{req_q.wdata}};

endmodule

// File: cache_top.sv
`include "cache_consts.svh"

module cache_top import cache_pkg::*; (
    input  logic            clk,
    input  logic            resetn,
    input  logic            valid,
    input  cpu_req_t        req,
    output logic            addr_ok,
    output logic            data_ok,
    output word_t           rdata,
    output logic            rd_req,
    output mem_rd_req_t     rd_info,
    input  logic            rd_rdy,
    input  logic            ret_valid,
    input  logic            ret_last,
    input  word_t           ret_data,
    output logic            wr_req,
    output mem_wr_req_t     wr_info,
    input  logic            wr_rdy,
    input  logic            wr_bvalid
);

    logic [1:0]                 way_hit;
    meta_t [1:0]                way_meta;
    line_t [1:0]                way_data;
    logic [`INDEX_W-1:0]        ctrl_index;
    logic [1:0]                 meta_we;
    meta_t                      meta_wdata;
    logic [1:0][`BANKS-1:0]     refill_we;
    word_t                      refill_word;
    logic                       sb_load;
    logic                       sb_conflict;
    logic                       sb_busy;
    logic                       sb_way;
    logic [`INDEX_W-1:0]        sb_index;
    logic [1:0]                 sb_bank;
    word_t                      sb_word;

    cache_ctrl ctrl_i (
        .clk         (clk),
        .resetn      (resetn),
        .valid       (valid),
        .req         (req),
        .addr_ok     (addr_ok),
        .data_ok     (data_ok),
        .rdata       (rdata),
        .way_hit     (way_hit),
        .way_meta    (way_meta),
        .way_data    (way_data),
        .way_index   (ctrl_index),
        .meta_we     (meta_we),
        .meta_wdata  (meta_wdata),
        .refill_we   (refill_we),
        .refill_word (refill_word),
        .sb_load     (sb_load),
        .sb_conflict (sb_conflict),
        .rd_req      (rd_req),
        .rd_info     (rd_info),
        .rd_rdy      (rd_rdy),
        .ret_valid   (ret_valid),
        .ret_last    (ret_last),
        .ret_data    (ret_data),
        .wr_req      (wr_req),
        .wr_info     (wr_info),
        .wr_rdy      (wr_rdy),
        .wr_bvalid   (wr_bvalid)
    );

    store_buffer sb_i (
        .clk         (clk),
        .resetn      (resetn),
        .load        (sb_load),
        .req         (req),
        .hit_way     (way_hit[1]),
        .hit_word    (rdata),           // lookup word of the hitting way
        .new_index   (req.index),
        .new_bank    (req.offset[3:2]),
        .new_is_read (!req.op),
        .busy        (sb_busy),
        .wr_way      (sb_way),
        .wr_index    (sb_index),
        .wr_bank     (sb_bank),
        .wr_word     (sb_word),
        .conflict    (sb_conflict)
    );

    for (genvar w = 0; w < 2; w++) begin : g_way
        logic                   sb_sel;
        logic [`INDEX_W-1:0]    index;
        logic [`BANKS-1:0]      bank_we;
        line_t                  bank_wdata;

        // store buffer write wins over refill and lookup
        assign sb_sel     = sb_busy && sb_way == 1'(w);
        assign index      = sb_sel ? sb_index : ctrl_index;
        assign bank_we    = sb_sel ? 4'b0001 << sb_bank : refill_we[w];
        assign bank_wdata = sb_sel ? {`BANKS{sb_word}} : {`BANKS{refill_word}};

        cache_way way_i (
            .clk        (clk),
            .resetn     (resetn),
            .index      (index),
            .req_tag    (req.tag),
            .meta_we    (meta_we[w]),
            .meta_wdata (meta_wdata),
            .bank_we    (bank_we),
            .bank_wdata (bank_wdata),
            .meta       (way_meta[w]),
            .hit        (way_hit[w]),
            .bank_data  (way_data[w])
        );
    end

endmodule

// File: tb_mem_model.sv
`include "cache_consts.svh"

module tb_mem_model import cache_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    input  logic        rd_req,
    input  mem_rd_req_t rd_info,
    output logic        rd_rdy,
    output logic        ret_valid,
    output logic        ret_last,
    output word_t       ret_data,
    input  logic        wr_req,
    input  mem_wr_req_t wr_info,
    output logic        wr_rdy,
    output logic        wr_bvalid
);

    localparam logic [31:0] FILL = 32'ha5a5_0000;

    word_t       mem [logic [29:0]];   // only written words are stored
    logic [1:0]  rd_wait;
    logic        rd_busy;
    logic [1:0]  ret_delay;
    logic [2:0]  beats_left;
    logic [29:0] rd_addr;
    logic [1:0]  wr_wait;
    logic [1:0]  b_delay;

    // untouched words read as word address xor fill
    function automatic word_t fetch(logic [29:0] waddr);
        if (mem.exists(waddr)) begin
            return mem[waddr];
        end
        return {2'b00, waddr} ^ FILL;
    endfunction

    task automatic write_mem(mem_wr_req_t w);
        word_t old;
        if (w.wtype == `RD_TYPE_LINE) begin
            for (int b = 0; b < 4; b++) begin
                mem[{w.addr[31:4], 2'(b)}] = w.data[b];
            end
        end else begin
            old = fetch(w.addr[31:2]);
            for (int i = 0; i < 4; i++) begin
                if (w.wstrb[i]) begin
                    old[8*i +: 8] = w.data[0][8*i +: 8];
                end
            end
            mem[w.addr[31:2]] = old;
        end
    endtask

    initial begin
        void'($urandom(90));
    end

    always @(posedge clk) begin
        if (!resetn) begin
            rd_rdy     <= 1'b0;
            rd_busy    <= 1'b0;
            ret_valid  <= 1'b0;
            ret_last   <= 1'b0;
            ret_data   <= '0;
            ret_delay  <= 2'd0;
            beats_left <= 3'd0;
            rd_addr    <= '0;
            rd_wait    <= 2'($urandom % 4);
        end else begin
            ret_valid <= 1'b0;
            ret_last  <= 1'b0;
            if (rd_req && rd_rdy) begin
                rd_rdy     <= 1'b0;
                rd_busy    <= 1'b1;
                rd_addr    <= rd_info.addr[31:2];
                beats_left <= rd_info.rtype == `RD_TYPE_LINE ? 3'd4 : 3'd1;
                ret_delay  <= 2'd1;
                rd_wait    <= 2'($urandom % 4);
            end else if (rd_req && !rd_busy) begin
                if (rd_wait == 2'd0) begin
                    rd_rdy <= 1'b1;
                end else begin
                    rd_wait <= rd_wait - 2'd1;
                end
            end
            if (rd_busy) begin
                if (ret_delay != 2'd0) begin
                    ret_delay <= ret_delay - 2'd1;
                end else begin
                    ret_valid  <= 1'b1;
                    ret_data   <= fetch(rd_addr);
                    ret_last   <= beats_left == 3'd1;
                    rd_addr    <= rd_addr + 30'd1;
                    beats_left <= beats_left - 3'd1;
                    rd_busy    <= beats_left != 3'd1;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (!resetn) begin
            wr_rdy    <= 1'b1;
            wr_wait   <= 2'd0;
            wr_bvalid <= 1'b0;
            b_delay   <= 2'd0;
        end else begin
            wr_bvalid <= 1'b0;
            if (wr_req) begin
                write_mem(wr_info);
                wr_rdy  <= 1'b0;
                wr_wait <= 2'($urandom % 4);
                if (wr_info.wtype == `RD_TYPE_WORD) begin
                    b_delay <= 2'd3;    // response 3 cycles on
                end
            end else if (!wr_rdy) begin
                if (wr_wait == 2'd0) begin
                    wr_rdy <= 1'b1;
                end else begin
                    wr_wait <= wr_wait - 2'd1;
                end
            end
            if (b_delay != 2'd0) begin
                b_delay   <= b_delay - 2'd1;
                wr_bvalid <= b_delay == 2'd1;
            end
        end
    end

endmodule

// File: tb_cache.sv
`include "cache_consts.svh"

module tb_cache import cache_pkg::*; ();

    logic        clk;
    logic        resetn;
    logic        valid;
    cpu_req_t    req;
    logic        addr_ok;
    logic        data_ok;
    word_t       rdata;
    logic        rd_req;
    mem_rd_req_t rd_info;
    logic        rd_rdy;
    logic        ret_valid;
    logic        ret_last;
    word_t       ret_data;
    logic        wr_req;
    mem_wr_req_t wr_info;
    logic        wr_rdy;
    logic        wr_bvalid;

    string       t_name[$];
    logic [3:0]  t_op[$];      // bit0 store, bit1 must finish one cycle after acceptance
    logic        t_cached[$];
    logic [31:0] t_addr[$];
    logic [3:0]  t_strb[$];
    word_t       t_wdata[$];
    word_t       t_exp[$];
    int          pend_idx[$];
    int          pend_cyc[$];
    int          last_acc = -1;
    int          cycle = 0;
    int          passed = 0;
    int          failed = 0;
    int          errors = 0;

    cache_top cache_top_i (.*);
    tb_mem_model mem_i (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic load_stim();
        int fd;
        string line;
        string name;
        logic [31:0] op, cached, addr, strb, wdata, exp;
        fd = $fopen("cache_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open cache_stim.txt");
            errors++;
            return;
        end
        while ($fgets(line, fd)) begin
            if (line.len() > 1 && line[0] != "#" &&
                $sscanf(line, "%s %h %h %h %h %h %h", name, op, cached, addr, strb,
                        wdata, exp) == 7) begin
                t_name.push_back(name);
                t_op.push_back(op[3:0]);
                t_cached.push_back(cached[0]);
                t_addr.push_back(addr);
                t_strb.push_back(strb[3:0]);
                t_wdata.push_back(wdata);
                t_exp.push_back(exp);
            end
        end
        $fclose(fd);
    endtask

    function automatic cpu_req_t make_req(int k);
        cpu_req_t r;
        r.op     = t_op[k][0];
        r.tag    = t_addr[k][31:12];
        r.index  = t_addr[k][`OFFSET_W +: `INDEX_W];
        r.offset = t_addr[k][`OFFSET_W-1:0];
        r.wstrb  = t_strb[k];
        r.wdata  = t_wdata[k];
        r.cached = t_cached[k];
        return r;
    endfunction

    task automatic complete_one();
        int k;
        int lat;
        logic bad;
        if (pend_idx.size() == 0) begin
            $display("data_ok seen with no request outstanding at cycle %0d", cycle);
            errors++;
            return;
        end
        k = pend_idx.pop_front();
        lat = cycle - pend_cyc.pop_front();
        bad = 1'b0;
        if (!t_op[k][0] && rdata !== t_exp[k]) begin
            $display("ERR %s rdata expected %08h actual %08h", t_name[k], t_exp[k], rdata);
            bad = 1'b1;
        end
        if (t_op[k][1] && lat != 1) begin
            $display("ERR %s latency expected 1 actual %0d", t_name[k], lat);
            bad = 1'b1;
        end
        if (bad) begin
            failed++;
        end else begin
            passed++;
        end
        $display("%s %s", bad ? "FAIL" : "ok  ", t_name[k]);
    endtask

    // miss traffic always belongs to the last accepted request
    task automatic watch_channels();
        logic [2:0]  ty;
        logic [31:0] a;
        if (last_acc < 0) begin
            return;
        end
        if (rd_req && rd_rdy) begin
            ty = t_cached[last_acc] ? `RD_TYPE_LINE : `RD_TYPE_WORD;
            a = t_cached[last_acc] ? {t_addr[last_acc][31:4], 4'h0} : t_addr[last_acc];
            if (rd_info.rtype !== ty || rd_info.addr !== a) begin
                $display("ERR %s read request expected %h/%08h actual %h/%08h",
                         t_name[last_acc], ty, a, rd_info.rtype, rd_info.addr);
                errors++;
            end
        end
        if (wr_req && t_cached[last_acc]) begin
            if (wr_info.wtype !== `RD_TYPE_LINE || wr_info.addr[3:0] !== 4'h0
                || wr_info.wstrb !== 4'hf) begin
                $display("ERR %s write-back expected %h/offset 0/f actual %h/%08h/%h",
                         t_name[last_acc], `RD_TYPE_LINE, wr_info.wtype, wr_info.addr,
                         wr_info.wstrb);
                errors++;
            end
        end else if (wr_req) begin
            if (wr_info.wtype !== `RD_TYPE_WORD || wr_info.addr !== t_addr[last_acc]
                || wr_info.wstrb !== t_strb[last_acc]
                || wr_info.data[0] !== t_wdata[last_acc]) begin
                $display("ERR %s uncached write expected %08h@%08h/%h actual %08h@%08h/%h",
                         t_name[last_acc], t_wdata[last_acc], t_addr[last_acc],
                         t_strb[last_acc], wr_info.data[0], wr_info.addr, wr_info.wstrb);
                errors++;
            end
        end
    endtask

    initial begin
        int n;
        int idx;
        int limit;
        logic accepted;
        resetn = 1'b0;
        valid  = 1'b0;
        req    = '0;
        idx    = 0;
        load_stim();
        n = t_name.size();
        limit = 60 * n;
        repeat (4) @(posedge clk);
        resetn <= 1'b1;
        @(negedge clk);
        if (addr_ok !== 1'b1 || data_ok !== 1'b0 || rd_req !== 1'b0 || wr_req !== 1'b0) begin
            $display("ERR reset expected addr_ok/data_ok/rd_req/wr_req 1000 actual %b%b%b%b",
                     addr_ok, data_ok, rd_req, wr_req);
            failed++;
        end else begin
            passed++;
            $display("ok   reset");
        end
        while (!(idx == n && pend_idx.size() == 0) && cycle <= limit) begin
            @(negedge clk);
            cycle++;
            if (data_ok) begin
                complete_one();
            end
            watch_channels();
            accepted = valid && addr_ok;
            @(posedge clk);
            if (accepted) begin
                pend_idx.push_back(idx);
                pend_cyc.push_back(cycle);
                last_acc = idx;
                idx++;
            end
            // hit-type requests go straight behind the previous one
            if (idx < n && (t_op[idx][1] || pend_idx.size() == 0)) begin
                valid <= 1'b1;
                req   <= make_req(idx);
            end else begin
                valid <= 1'b0;
            end
        end
        if (cycle > limit) begin
            $display("timeout after %0d cycles, %0d requests not finished", cycle,
                     n - idx + pend_idx.size());
            errors++;
        end
        $display("tests %0d, passed %0d, failed %0d, other errors %0d",
                 passed + failed, passed, failed, errors);
        if (failed == 0 && errors == 0 && n > 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: cache_stim.txt
# name op cached addr wstrb wdata expected_rdata (hex)
# op bit0 store, bit1 completes one cycle after acceptance
rd_miss_fill     0 1 00001004 0 00000000 a5a50401
rd_hit_same      2 1 00001004 0 00000000 a5a50401
wr_hit_strb      3 1 00001008 3 deadbeef 00000000
rd_after_strb    2 1 00001008 0 00000000 a5a5beef
wr_alloc_a       1 1 00002100 f 11111111 00000000
wr_alloc_b       1 1 00003100 f 22222222 00000000
wr_alloc_c       1 1 00004100 f 33333333 00000000
rd_evicted_a     0 1 00002100 0 00000000 11111111
rd_evicted_b     0 1 00003100 0 00000000 22222222
rd_evicted_c     0 1 00004100 0 00000000 33333333
rd_evicted_word  0 1 00002104 0 00000000 a5a50841
uc_write         3 0 00008020 f cafef00d 00000000
uc_read          0 0 00008020 0 00000000 cafef00d
uc_read_fill     0 0 00008024 0 00000000 a5a52009
b2b_bank0        2 1 00001000 0 00000000 a5a50400
b2b_bank3        2 1 0000100c 0 00000000 a5a50403
b2b_bank1        2 1 00001004 0 00000000 a5a50401
b2b_bank2        2 1 00001008 0 00000000 a5a5beef

// File: src.f
+incdir+.
cache_pkg.sv
sync_ram.sv
cache_way.sv
store_buffer.sv
cache_ctrl.sv
cache_top.sv
tb_mem_model.sv
tb_cache.sv

// File: run.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f src.f --top-module tb_cache -o tb_cache_sim
./obj_dir/tb_cache_sim | tee sim.log

if grep -q "Test failures found" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
